// File: Bender.yml
package:
  name: apu

sources:
  - rtl/apuPkg.sv
  - rtl/pulseCtrlIf.sv
  - rtl/apuBusControl.sv
  - rtl/frameSequencer.sv
  - rtl/envelopeUnit.sv
  - rtl/sweepUnit.sv
  - rtl/pulseChannel.sv
  - rtl/apuTop.sv
  - target: test
    files:
      - verif/apuTb.sv

// File: rtl/apuBusControl.sv
// ----------------------------------------------------------------------
// CPU register bus decode, channel enable register, status read and IRQ
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module apuBusControl (
  input  logic       clk,
  input  logic       reset,
  input  logic [4:0] addr,
  input  logic [7:0] din,
  input  logic       write,
  input  logic       read,
  input  logic       pulse1Active,
  input  logic       pulse2Active,
  input  logic       frameIrq,
  output logic [7:0] dout,
  output logic       irq,
  output logic       frameClear,
  output logic       frameWrite,
  pulseCtrlIf.bus    pulse1,
  pulseCtrlIf.bus    pulse2
);

  logic [1:0] enableBits;  // Bit 0 pulse 1, bit 1 pulse 2
  logic       statusRead;

  always_ff @(posedge clk) begin
    if (reset) begin
      enableBits <= 2'b00;
    end else if (write && addr == apuPkg::statusAddr) begin
      enableBits <= din[1:0];
    end
  end

  // Per-channel register writes by address group
  assign pulse1.write    = write && (addr[4:2] == apuPkg::pulse1Group);
  assign pulse1.regIndex = addr[1:0];
  assign pulse1.data     = din;
  assign pulse1.enabled  = enableBits[0];

  assign pulse2.write    = write && (addr[4:2] == apuPkg::pulse2Group);
  assign pulse2.regIndex = addr[1:0];
  assign pulse2.data     = din;
  assign pulse2.enabled  = enableBits[1];

  assign frameWrite = write && (addr == apuPkg::frameCtrlAddr);

  // Status read, which also acknowledges the frame interrupt
  assign statusRead = read && (addr == apuPkg::statusAddr);
  assign frameClear = statusRead;

  // Bits of the dropped channels and the DMC flag read zero
  assign dout = statusRead ? {1'b0, frameIrq, 4'b0000, pulse2Active, pulse1Active} : 8'h00;

  assign irq = frameIrq;

  // The CPU issues one bus cycle at a time
  busOneAccess: assert property (@(posedge clk) disable iff (reset) !(write && read))
    else $error("Bus write and read in the same cycle");

endmodule

// File: rtl/apuPkg.sv
// ----------------------------------------------------------------------
// APU shared definitions: register map, frame-step counts, length table,
// duty patterns and field types
// ----------------------------------------------------------------------
package apuPkg;

  // Field types
  typedef logic [10:0] periodT;  // Pulse timer period
  typedef logic [3:0]  volumeT;  // Volume, envelope level or sample
  typedef logic [7:0]  lengthT;  // Length counter
  typedef logic [1:0]  regIndexT;
  typedef logic [1:0]  dutyT;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  localparam logic [4:0] statusAddr    = 5'h15;  // $4015
  localparam logic [4:0] frameCtrlAddr = 5'h17;  // $4017
  localparam logic [2:0] pulse1Group   = 3'd0;   // $4000-$4003
  localparam logic [2:0] pulse2Group   = 3'd1;   // $4004-$4007

  // Frame sequencer step counts in CPU cycles
  localparam logic [15:0] stepQuarter1    = 16'd7457;
  localparam logic [15:0] stepHalf1       = 16'd14913;
  localparam logic [15:0] stepQuarter3    = 16'd22371;
  localparam logic [15:0] stepFourEnd     = 16'd29829;
  localparam logic [15:0] stepFiveEnd     = 16'd37281;
  localparam logic [15:0] frameResetCount = 16'd5;  // Power-up offset

  localparam volumeT envelopeMax = 4'd15;
  localparam periodT minPeriod   = 11'd8;  // Shorter periods are muted

  // Length loads indexed by data bits 7:3, already doubled
  localparam lengthT lengthTable [32] = '{
    8'd10,  8'd254, 8'd20,  8'd2,
    8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,
    8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,
    8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,
    8'd16,  8'd28,  8'd32,  8'd30
  };

  // Bit p set means high at sequencer position p
  localparam logic [7:0] dutyPatterns [4] = '{
    8'b1000_0000,  // 12.5%
    8'b1100_0000,  // 25%
    8'b1111_0000,  // 50%
    8'b0011_1111   // 75%, inverted 25%
  };

endpackage

// File: rtl/apuTop.sv
// ----------------------------------------------------------------------
// APU top level: bus controller, frame sequencer and two pulse channels
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module apuTop (
  input  logic           clk,
  input  logic           reset,
  input  logic [4:0]     addr,
  input  logic [7:0]     din,
  input  logic           write,
  input  logic           read,
  output logic [7:0]     dout,
  output logic           irq,
  output apuPkg::volumeT pulse1Sample,
  output apuPkg::volumeT pulse2Sample
);

  logic quarterFrame;
  logic halfFrame;
  logic frameIrq;
  logic frameClear;
  logic frameWrite;
  logic pulse1Active;
  logic pulse2Active;

  pulseCtrlIf pulse1If ();
  pulseCtrlIf pulse2If ();

  apuBusControl u_busControl (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .din          (din),
    .write        (write),
    .read         (read),
    .pulse1Active (pulse1Active),
    .pulse2Active (pulse2Active),
    .frameIrq     (frameIrq),
    .dout         (dout),
    .irq          (irq),
    .frameClear   (frameClear),
    .frameWrite   (frameWrite),
    .pulse1       (pulse1If.bus),
    .pulse2       (pulse2If.bus)
  );

  frameSequencer u_frameSequencer (
    .clk          (clk),
    .reset        (reset),
    .din          (din),
    .frameWrite   (frameWrite),
    .frameClear   (frameClear),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .frameIrq     (frameIrq)
  );

  // Pulse 1 uses ones' complement negate in the sweep
  pulseChannel #(.onesComplement(1'b1)) u_pulse1 (
    .clk          (clk),
    .reset        (reset),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .ctrl         (pulse1If.channel),
    .sample       (pulse1Sample),
    .lengthActive (pulse1Active)
  );

  pulseChannel #(.onesComplement(1'b0)) u_pulse2 (
    .clk          (clk),
    .reset        (reset),
    .quarterFrame (quarterFrame),
    .halfFrame    (halfFrame),
    .ctrl         (pulse2If.channel),
    .sample       (pulse2Sample),
    .lengthActive (pulse2Active)
  );

endmodule

// File: rtl/envelopeUnit.sv
// ----------------------------------------------------------------------
// Envelope generator: divider and decaying level
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module envelopeUnit (
  input  logic           clk,
  input  logic           reset,
  input  logic           quarterFrame,
  input  logic           restart,    // Pending start from register 3
  input  logic           loopFlag,
  input  apuPkg::volumeT divPeriod,
  output apuPkg::volumeT level
);

  apuPkg::volumeT divider;

  always_ff @(posedge clk) begin
    if (reset) begin
      divider <= '0;
      level   <= '0;
    end else if (quarterFrame) begin
      if (restart) begin
        level   <= apuPkg::envelopeMax;
        divider <= divPeriod;
      end else if (divider == '0) begin
        divider <= divPeriod;
        // Decay, or wrap back to full when looping
        if (level != '0) begin
          level <= level - 4'd1;
        end else if (loopFlag) begin
          level <= apuPkg::envelopeMax;
        end
      end else begin
        divider <= divider - 4'd1;
      end
    end
  end

endmodule

// File: rtl/frameSequencer.sv
// ----------------------------------------------------------------------
// Frame sequencer with step counter, quarter/half-frame strobes, frame IRQ
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module frameSequencer (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] din,
  input  logic       frameWrite,
  input  logic       frameClear,
  output logic       quarterFrame,
  output logic       halfFrame,
  output logic       frameIrq
);

  logic [15:0] frameCount;
  logic        fiveStep;      // Mode bit, 1 = 5-step
  logic        irqInhibit;
  logic        irqFlag;
  logic        parity;        // Even/odd CPU cycle
  logic        writePending;  // Mode write landed on an odd cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      frameCount   <= apuPkg::frameResetCount;
      fiveStep     <= 1'b0;
      irqInhibit   <= 1'b0;
      irqFlag      <= 1'b0;
      parity       <= 1'b0;
      writePending <= 1'b0;
      quarterFrame <= 1'b0;
      halfFrame    <= 1'b0;
    end else begin
      parity       <= ~parity;
      frameCount   <= frameCount + 16'd1;
      quarterFrame <= 1'b0;
      halfFrame    <= 1'b0;
      writePending <= 1'b0;

      if (frameClear) irqFlag <= 1'b0;  // A flag raised this cycle still wins

      // ------------------------------------------------------------------
      // Step decode with strobes one cycle after the match
      // ------------------------------------------------------------------
      case (frameCount)
        apuPkg::stepQuarter1, apuPkg::stepQuarter3: begin
          quarterFrame <= 1'b1;
        end
        apuPkg::stepHalf1: begin
          quarterFrame <= 1'b1;
          halfFrame    <= 1'b1;
        end
        apuPkg::stepFourEnd: begin
          if (!fiveStep) begin
            quarterFrame <= 1'b1;
            halfFrame    <= 1'b1;
            frameCount   <= 16'd0;
            if (!irqInhibit) irqFlag <= 1'b1;
          end
        end
        apuPkg::stepFiveEnd: begin
          quarterFrame <= 1'b1;
          halfFrame    <= 1'b1;
          frameCount   <= 16'd0;
        end
        default: ;
      endcase

      // Delayed restart from a write on an odd cycle
      if (writePending) begin
        if (fiveStep) begin
          quarterFrame <= 1'b1;
          halfFrame    <= 1'b1;
        end
        frameCount <= 16'd0;
      end

      if (frameWrite) begin
        fiveStep   <= din[7];
        irqInhibit <= din[6];
        if (din[6]) irqFlag <= 1'b0;
        if (!parity) begin
          if (din[7]) begin
            quarterFrame <= 1'b1;
            halfFrame    <= 1'b1;
          end
          frameCount <= 16'd0;
        end
        writePending <= parity;
      end
    end
  end

  assign frameIrq = irqFlag && !irqInhibit;

  // The step counter never runs past the 5-step frame end
  countInRange: assert property (@(posedge clk) disable iff (reset)
    frameCount <= apuPkg::stepFiveEnd)
    else $error("Frame step counter beyond the 5-step frame end");

endmodule

// File: rtl/pulseChannel.sv
// ----------------------------------------------------------------------
// Pulse channel registers, timer, duty sequencer, length counter, output
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module pulseChannel #(
  parameter bit onesComplement = 1'b0
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           quarterFrame,
  input  logic           halfFrame,
  pulseCtrlIf.channel    ctrl,
  output apuPkg::volumeT sample,
  output logic           lengthActive
);

  apuPkg::dutyT   duty;
  logic           loopHalt;     // Envelope loop, also length halt
  logic           constVol;
  apuPkg::volumeT volume;       // Constant volume or envelope period
  apuPkg::periodT period;
  apuPkg::periodT timer;
  logic           timerPhase;   // Timer runs on every second cycle
  logic [2:0]     seqPos;
  apuPkg::lengthT lengthCnt;
  logic           envStart;
  apuPkg::volumeT envLevel;
  apuPkg::periodT sweepNewPeriod;
  logic           sweepUpdate;
  logic           sweepMute;
  logic           dutyBit;

  envelopeUnit u_envelope (
    .clk          (clk),
    .reset        (reset),
    .quarterFrame (quarterFrame),
    .restart      (envStart),
    .loopFlag     (loopHalt),
    .divPeriod    (volume),
    .level        (envLevel)
  );

  sweepUnit #(.onesComplement(onesComplement)) u_sweep (
    .clk       (clk),
    .reset     (reset),
    .halfFrame (halfFrame),
    .setup     (ctrl.write && ctrl.regIndex == 2'd1),
    .din       (ctrl.data),
    .period    (period),
    .newPeriod (sweepNewPeriod),
    .update    (sweepUpdate),
    .mute      (sweepMute)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      duty       <= '0;
      loopHalt   <= 1'b0;
      constVol   <= 1'b0;
      volume     <= '0;
      period     <= '0;
      timer      <= '0;
      timerPhase <= 1'b0;
      seqPos     <= 3'd0;
      lengthCnt  <= '0;
      envStart   <= 1'b0;
    end else begin
      // ------------------------------------------------------------------
      // Timer and sequencer
      // ------------------------------------------------------------------
      timerPhase <= ~timerPhase;
      if (timerPhase) begin
        if (timer == '0) begin
          timer  <= period;
          seqPos <= seqPos - 3'd1;
        end else begin
          timer <= timer - 11'd1;
        end
      end

      if (sweepUpdate) period <= sweepNewPeriod;
      if (quarterFrame) envStart <= 1'b0;  // Taken by the envelope
      if (halfFrame && lengthCnt != '0 && !loopHalt) lengthCnt <= lengthCnt - 8'd1;

      // Register writes take priority over the clocked updates
      if (ctrl.write) begin
        case (ctrl.regIndex)
          2'd0: begin
            duty     <= ctrl.data[7:6];
            loopHalt <= ctrl.data[5];
            constVol <= ctrl.data[4];
            volume   <= ctrl.data[3:0];
          end
          2'd2: period[7:0] <= ctrl.data;
          2'd3: begin
            period[10:8] <= ctrl.data[2:0];
            lengthCnt    <= apuPkg::lengthTable[ctrl.data[7:3]];
            seqPos       <= 3'd0;
            envStart     <= 1'b1;
          end
          default: ;  // Register 1 belongs to the sweep unit
        endcase
      end

      if (!ctrl.enabled) lengthCnt <= '0;
    end
  end

  assign dutyBit      = apuPkg::dutyPatterns[duty][seqPos];
  assign sample       = (lengthCnt == '0 || sweepMute || !dutyBit) ? '0
                      : (constVol ? volume : envLevel);
  assign lengthActive = ctrl.enabled && (lengthCnt != '0);

  // A length load with the channel enabled shows in status next cycle
  lengthLoadActive: assert property (@(posedge clk) disable iff (reset)
    ctrl.write && ctrl.regIndex == 2'd3 && ctrl.enabled |=> lengthActive)
    else $error("Length load did not activate the channel");

endmodule

// File: rtl/pulseCtrlIf.sv
// ----------------------------------------------------------------------
// Register write and enable link from the bus controller to a pulse channel
// ----------------------------------------------------------------------
`timescale 1ns/1ps

interface pulseCtrlIf;

  logic             write;     // One-cycle register write strobe
  apuPkg::regIndexT regIndex;  // Register within the channel
  logic [7:0]       data;
  logic             enabled;   // Channel bit of the enable register

  modport bus (output write, output regIndex, output data, output enabled);

  modport channel (input write, input regIndex, input data, input enabled);

endinterface

// File: rtl/sweepUnit.sv
// ----------------------------------------------------------------------
// Sweep unit: divider, target period and mute decision
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sweepUnit #(
  parameter bit onesComplement = 1'b0  // Pulse 1 negates with one extra subtract
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           halfFrame,
  input  logic           setup,      // Write to register 1
  input  logic [7:0]     din,
  input  apuPkg::periodT period,
  output apuPkg::periodT newPeriod,
  output logic           update,
  output logic           mute
);

  logic           sweepEnable;
  logic [2:0]     divPeriod;
  logic           negate;
  logic [2:0]     shift;
  logic           reload;
  logic [2:0]     divider;
  apuPkg::periodT shifted;
  apuPkg::periodT change;
  logic [11:0]    target;       // Bit 11 flags overflow

  always_ff @(posedge clk) begin
    if (reset) begin
      sweepEnable <= 1'b0;
      divPeriod   <= 3'd0;
      negate      <= 1'b0;
      shift       <= 3'd0;
      reload      <= 1'b0;
      divider     <= 3'd0;
    end else begin
      if (halfFrame) begin
        if (divider == 3'd0 || reload) divider <= divPeriod;
        else divider <= divider - 3'd1;
        reload <= 1'b0;
      end
      if (setup) begin
        sweepEnable <= din[7];
        divPeriod   <= din[6:4];
        negate      <= din[3];
        shift       <= din[2:0];
        reload      <= 1'b1;
      end
    end
  end

  // Target period
  assign shifted   = period >> shift;
  assign change    = negate ? (~shifted + (onesComplement ? 11'd0 : 11'd1)) : shifted;
  assign target    = {1'b0, period} + {1'b0, change};
  assign newPeriod = target[10:0];

  assign mute   = (period < apuPkg::minPeriod) || (!negate && target[11]);
  assign update = halfFrame && divider == 3'd0 && sweepEnable && shift != 3'd0 && !mute;

endmodule

// File: verif/apuTb.sv
// ----------------------------------------------------------------------
// APU testbench: clock, bus tasks, sample reference, checks and report
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module apuTb;

  logic           clk;
  logic           reset;
  logic [4:0]     addr;
  logic [7:0]     din;
  logic           write;
  logic           read;
  logic [7:0]     dout;
  logic           irq;
  apuPkg::volumeT pulse1Sample;
  apuPkg::volumeT pulse2Sample;

  int unsigned lcgState    = 41837;
  int          errorCount  = 0;
  int          testsRun    = 0;
  int          testsFailed = 0;
  int          cycleCount  = 0;     // Rising edges since time zero
  logic        muteWatch   = 1'b0;  // Both samples must stay zero
  logic        irqLowWatch = 1'b0;

  localparam logic [4:0] pulse1Base = {apuPkg::pulse1Group, 2'b00};
  localparam logic [4:0] pulse2Base = {apuPkg::pulse2Group, 2'b00};

  apuTop i_apuTop (
    .clk          (clk),
    .reset        (reset),
    .addr         (addr),
    .din          (din),
    .write        (write),
    .read         (read),
    .dout         (dout),
    .irq          (irq),
    .pulse1Sample (pulse1Sample),
    .pulse2Sample (pulse2Sample)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic int unsigned nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return (lcgState >> 16) & 32'h7fff;
  endfunction

  // Expected pulse output from duty table, position, volume and mute
  function automatic apuPkg::volumeT expectedSample(input apuPkg::dutyT duty,
      input logic [2:0] pos, input apuPkg::volumeT volume, input logic muted);
    if (muted || !apuPkg::dutyPatterns[duty][pos]) begin
      return 4'd0;
    end
    return volume;
  endfunction

  // Cycles from a 5-step mode write to the k-th length decrement
  function automatic int halfFrameEdge(input int k);
    int frames;
    frames = (k - 1) / 2;
    return frames * (apuPkg::stepFiveEnd + 1) + 2
         + ((k % 2) ? int'(apuPkg::stepHalf1) : int'(apuPkg::stepFiveEnd));
  endfunction

  function automatic apuPkg::volumeT getSample(input logic sel);
    return sel ? pulse2Sample : pulse1Sample;
  endfunction

  task automatic reportValue(input string name, input int got, input int exp);
    $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    errorCount++;
  endtask

  task automatic reportIssue(input string msg);
    $display("at %0t ns: %s", $time, msg);
    errorCount++;
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    if (errorCount == errorsBefore) begin
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: failed", name);
    end
  endtask

  // Bus tasks are entered on a falling edge and return on the next one
  task automatic writeReg(input logic [4:0] a, input logic [7:0] d);
    addr  = a;
    din   = d;
    write = 1'b1;
    @(negedge clk);
    write = 1'b0;
  endtask

  task automatic readReg(input logic [4:0] a, output logic [7:0] d);
    addr = a;
    read = 1'b1;
    #1 d = dout;
    @(negedge clk);
    read = 1'b0;
  endtask

  task automatic loadPulse(input logic [4:0] base, input logic [7:0] ctrl0,
      input logic [7:0] sweep, input apuPkg::periodT period, input logic [4:0] lenIdx);
    writeReg(base, ctrl0);
    writeReg(base + 5'd1, sweep);
    writeReg(base + 5'd2, period[7:0]);
    writeReg(base + 5'd3, {lenIdx, period[10:8]});
  endtask

  // Holds a status read until the given bit drops
  task automatic waitStatusLow(input int bitIdx, input int maxCycles, output int seen);
    int  n;
    logic done;
    done = 1'b0;
    seen = -1;
    addr = apuPkg::statusAddr;
    read = 1'b1;
    for (n = 0; n < maxCycles && !done; n++) begin
      #1;
      if (!dout[bitIdx]) begin
        done = 1'b1;
        seen = cycleCount;
      end
      @(negedge clk);
    end
    read = 1'b0;
    if (!done) reportIssue("timeout waiting for a status bit to fall");
  endtask

  task automatic waitIrqHigh(input int maxCycles, output int seen);
    int  n;
    logic done;
    done = 1'b0;
    seen = -1;
    for (n = 0; n < maxCycles && !done; n++) begin
      @(negedge clk);
      if (irq) begin
        done = 1'b1;
        seen = cycleCount;
      end
    end
    if (!done) reportIssue("timeout waiting for irq to rise");
  endtask

  // Next nonzero sample that differs from the previous level
  task automatic waitNewLevel(input logic sel, input apuPkg::volumeT prev,
      input int maxCycles, output apuPkg::volumeT level);
    int  n;
    logic done;
    done  = 1'b0;
    level = prev;
    for (n = 0; n < maxCycles && !done; n++) begin
      @(negedge clk);
      if (getSample(sel) != 4'd0 && getSample(sel) != prev) begin
        done  = 1'b1;
        level = getSample(sel);
      end
    end
    if (!done) reportIssue("timeout waiting for an envelope level change");
  endtask

  task automatic countVolumeHits(input logic sel, input apuPkg::volumeT vol,
      input int window, output int hits);
    hits = 0;
    repeat (window) begin
      @(negedge clk);
      if (getSample(sel) == vol) begin
        hits++;
      end else if (getSample(sel) != 4'd0) begin
        reportValue("pulse1Sample", getSample(sel), vol);
      end
    end
  endtask

  // Compare process for mute and inhibit windows
  always @(posedge clk) begin
    if (muteWatch && pulse1Sample != 4'd0) reportValue("pulse1Sample", pulse1Sample, 0);
    if (muteWatch && pulse2Sample != 4'd0) reportValue("pulse2Sample", pulse2Sample, 0);
    if (irqLowWatch && irq !== 1'b0) reportValue("irq", irq, 0);
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    logic [7:0]     data;
    int             errorsBefore;
    int             startCycle;
    int             seenCycle;
    int             expCycles;
    int             hits;
    int             expHits;
    int             stepCycles;
    int             k;
    int             p;
    apuPkg::dutyT   duty;
    apuPkg::volumeT vol;
    apuPkg::volumeT level;
    apuPkg::periodT period;
    logic [4:0]     lenIdx;

    reset = 1'b1;
    addr  = '0;
    din   = '0;
    write = 1'b0;
    read  = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Reset state
    errorsBefore = errorCount;
    if (irq !== 1'b0) reportValue("irq", irq, 0);
    if (pulse1Sample !== 4'd0) reportValue("pulse1Sample", pulse1Sample, 0);
    if (pulse2Sample !== 4'd0) reportValue("pulse2Sample", pulse2Sample, 0);
    readReg(apuPkg::statusAddr, data);
    if (data !== 8'h00) reportValue("dout", data, 0);
    finishTest("reset state", errorsBefore);

    // Status flags follow length loads and the enable register
    errorsBefore = errorCount;
    writeReg(apuPkg::statusAddr, 8'h03);
    writeReg(pulse1Base + 5'd3, {5'(nextRandom() % 32), 3'b000});
    readReg(apuPkg::statusAddr, data);
    if (data[0] !== 1'b1) reportValue("dout[0]", data[0], 1);
    writeReg(pulse2Base + 5'd3, {5'(nextRandom() % 32), 3'b000});
    readReg(apuPkg::statusAddr, data);
    if (data[1:0] !== 2'b11) reportValue("dout[1:0]", data[1:0], 3);
    writeReg(apuPkg::statusAddr, 8'h00);
    readReg(apuPkg::statusAddr, data);
    if (data[1:0] !== 2'b00) reportValue("dout[1:0]", data[1:0], 0);
    finishTest("status flags", errorsBefore);

    // Length expiry in 5-step mode, halt clear
    errorsBefore = errorCount;
    writeReg(apuPkg::statusAddr, 8'h01);
    writeReg(apuPkg::frameCtrlAddr, 8'hC0);
    startCycle = cycleCount;
    @(negedge clk);
    @(negedge clk);
    lenIdx = 5'd3 + 5'd2 * 5'(nextRandom() % 3);  // Loads of 2, 4 or 6
    loadPulse(pulse1Base, 8'h1F, 8'h00, 11'h100, lenIdx);
    expCycles = halfFrameEdge(apuPkg::lengthTable[lenIdx]);
    waitStatusLow(0, expCycles + 100, seenCycle);
    if (seenCycle >= 0) begin
      if (seenCycle - startCycle < expCycles - 2 || seenCycle - startCycle > expCycles + 2) begin
        reportValue("pulse1 length expiry cycle", seenCycle - startCycle, expCycles);
      end
    end
    finishTest("length expiry", errorsBefore);

    // Constant-volume duty output over one full sequence
    errorsBefore = errorCount;
    duty   = apuPkg::dutyT'(nextRandom() % 4);
    vol    = apuPkg::volumeT'(1 + nextRandom() % 15);
    period = apuPkg::minPeriod + apuPkg::periodT'(nextRandom() % 200);
    writeReg(apuPkg::statusAddr, 8'h01);
    loadPulse(pulse1Base, {duty, 2'b11, vol}, 8'h00, period, 5'd1);
    stepCycles = 2 * (int'(period) + 1);
    expHits = 0;
    for (p = 0; p < 8; p++) begin
      if (expectedSample(duty, 3'(p), vol, 1'b0) == vol) expHits += stepCycles;
    end
    countVolumeHits(1'b0, vol, 8 * stepCycles, hits);
    if (hits < expHits - stepCycles || hits > expHits + stepCycles) begin
      reportValue("pulse1Sample volume count", hits, expHits);
    end
    finishTest("duty output", errorsBefore);

    // Envelope decay on pulse 2, then looping decay on pulse 1
    errorsBefore = errorCount;
    writeReg(apuPkg::statusAddr, 8'h02);
    loadPulse(pulse2Base, 8'hC0, 8'h00, apuPkg::minPeriod, 5'd1);
    writeReg(apuPkg::frameCtrlAddr, 8'hC0);  // Immediate quarter frame
    @(negedge clk);
    @(negedge clk);
    waitNewLevel(1'b1, 4'd0, 30000, level);
    if (level != apuPkg::envelopeMax) reportValue("pulse2Sample", level, apuPkg::envelopeMax);
    for (k = 1; k <= 3; k++) begin
      waitNewLevel(1'b1, level, 30000, level);
      if (level != apuPkg::envelopeMax - k) begin
        reportValue("pulse2Sample", level, apuPkg::envelopeMax - k);
      end
    end
    writeReg(apuPkg::statusAddr, 8'h01);
    loadPulse(pulse1Base, 8'hE0, 8'h00, apuPkg::minPeriod, 5'd1);
    writeReg(apuPkg::frameCtrlAddr, 8'hC0);
    @(negedge clk);
    @(negedge clk);
    waitNewLevel(1'b0, 4'd0, 30000, level);
    if (level != apuPkg::envelopeMax) reportValue("pulse1Sample", level, apuPkg::envelopeMax);
    for (k = 1; k <= 15; k++) begin
      waitNewLevel(1'b0, level, 30000, level);
      // Level 0 gives a silent quarter, then the loop wraps to full
      if (level != ((k == 15) ? apuPkg::envelopeMax : apuPkg::envelopeMax - k)) begin
        reportValue("pulse1Sample", level, (k == 15) ? apuPkg::envelopeMax
                                                     : apuPkg::envelopeMax - k);
      end
    end
    finishTest("envelope decay", errorsBefore);

    // Sweep mute with a short period and with an overflowing target
    errorsBefore = errorCount;
    writeReg(apuPkg::statusAddr, 8'h00);
    writeReg(apuPkg::statusAddr, 8'h03);
    loadPulse(pulse1Base, 8'hFF, 8'h00, 11'd5, 5'd1);
    loadPulse(pulse2Base, 8'hFF, 8'h00, 11'h500, 5'd1);
    muteWatch = 1'b1;
    repeat (6000) @(negedge clk);
    muteWatch = 1'b0;
    readReg(apuPkg::statusAddr, data);
    if (data[1:0] !== 2'b11) reportValue("dout[1:0]", data[1:0], 3);
    finishTest("sweep mute", errorsBefore);

    // Frame interrupt in 4-step mode, then inhibited
    errorsBefore = errorCount;
    readReg(apuPkg::statusAddr, data);
    writeReg(apuPkg::frameCtrlAddr, 8'h00);
    startCycle = cycleCount;
    waitIrqHigh(apuPkg::stepFourEnd + 100, seenCycle);
    if (seenCycle >= 0) begin
      expCycles = apuPkg::stepFourEnd + 1;
      if (seenCycle - startCycle < expCycles - 2 || seenCycle - startCycle > expCycles + 2) begin
        reportValue("irq rise cycle", seenCycle - startCycle, expCycles);
      end
    end
    readReg(apuPkg::statusAddr, data);
    if (data[6] !== 1'b1) reportValue("dout[6]", data[6], 1);
    if (irq !== 1'b0) reportValue("irq", irq, 0);
    writeReg(apuPkg::frameCtrlAddr, 8'h40);
    irqLowWatch = 1'b1;
    repeat (2 * (apuPkg::stepFourEnd + 1) + 50) @(negedge clk);
    irqLowWatch = 1'b0;
    finishTest("frame interrupt", errorsBefore);

    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: vlog.f
rtl/apuPkg.sv
rtl/pulseCtrlIf.sv
rtl/apuBusControl.sv
rtl/frameSequencer.sv
rtl/envelopeUnit.sv
rtl/sweepUnit.sv
rtl/pulseChannel.sv
rtl/apuTop.sv
verif/apuTb.sv
